// ==== sim/csr_stim.txt ====
# Columns: op addr data cause expect, all hex; "test <name>" starts a new test
# read cause: 0 exact, 1 delta from last read, 2 last write masked by expect, 3 capture only
# write cause 1 takes random data; irq data is {ext,timer,soft}, addr is epc, cause 1 = trap
# exc: addr epc, data tval, expect trap_pc; mret data 1 adds an exception with cause
test reset_values
read   301 00000000 0 40001100
read   300 00000000 0 00001800
read   305 00000000 0 00000000
test masking
write  340 00000000 1 00000000
read   340 00000000 2 ffffffff
write  340 00000000 1 00000000
read   340 00000000 2 ffffffff
write  305 00000000 1 00000000
read   305 00000000 2 fffffffd
write  304 00000000 1 00000000
read   304 00000000 2 00000bbb
write  301 00000000 1 00000000
read   301 00000000 2 c3ffffff
write  300 ffffffff 0 00000000
read   300 00000000 0 807ff9bb
write  344 ffffffff 0 00000000
read   344 00000000 0 00000333
write  7c0 12345678 0 00000000
read   7c0 00000000 0 00000000
write  300 00001800 0 00000000
write  304 00000000 0 00000000
write  344 00000000 0 00000000
test counters
read   b00 00000000 3 00000000
idle   000 00000004 0 00000000
read   b00 00000000 1 00000005
read   b02 00000000 3 00000000
retire 000 00000003 0 00000000
read   b02 00000000 1 00000003
write  b80 00000005 0 00000000
read   b80 00000000 0 00000005
write  b02 00000100 0 00000000
read   b02 00000000 0 00000100
retire 000 00000002 0 00000000
read   b02 00000000 0 00000102
test exception
write  300 00001808 0 00000000
write  305 00000100 0 00000000
exc    2000 0000dead 2 00000100
read   341 00000000 0 00002000
read   342 00000000 0 00000002
read   343 00000000 0 0000dead
read   300 00000000 0 00001880
test mret
mret   000 00000000 0 00002000
read   300 00000000 0 00001888
test interrupts
write  304 00000888 0 00000000
write  305 00000201 0 00000000
irq    3000 00000007 1 0000022c
read   342 00000000 0 8000000b
read   300 00000000 0 00001880
irq    3000 00000003 0 00000000
mret   000 00000000 0 00003000
irq    3400 00000003 1 0000021c
read   342 00000000 0 80000007
irq    000 00000000 0 00000000
write  300 00001800 0 00000000
irq    000 00000007 0 00000000
read   344 00000000 0 00000888
irq    000 00000000 0 00000000
test trap_and_mret
mret   4000 00000001 3 00000200
read   342 00000000 0 00000003
read   341 00000000 0 00004000
read   300 00000000 0 00001800

// ==== sources.f ====
hdl/csr_pkg.sv
hdl/csr_regs.sv
hdl/csr_counters.sv
hdl/trap_ctrl.sv
hdl/csr_unit.sv
sim/csr_unit_assert.sv
sim/tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_csr_unit -f sources.f -o tb_csr_unit
# Keep running past assertion errors so the testbench prints its summary
./obj_dir/tb_csr_unit +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit
  import csr_pkg::*;
();

  localparam int wait_limit   = 8;  // Cycles allowed for a trap or mret pulse
  localparam int quiet_cycles = 6;
  localparam int wd_per_line  = 20;
  localparam int wd_margin    = 200;

  logic     clk = 1'b0;
  logic     rst;
  csr_req_t req;
  logic     irq_ext;
  logic     irq_timer;
  logic     irq_soft;
  csr_rsp_t rsp;

  string           stim_lines[$];
  string           test_name = "";
  int              n_tests = 0;
  int              n_checks = 0;
  int              n_errors = 0;
  int              test_checks = 0;
  int              test_errors = 0;
  int              wd_cycles = 0;
  logic [xlen-1:0] rng = 32'd92282;
  logic [xlen-1:0] last_wdata = '0;  // Model of the most recent write
  logic [xlen-1:0] prev_rd = '0;

  always #5 clk = ~clk;

  csr_unit i_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .irq_ext   (irq_ext),
    .irq_timer (irq_timer),
    .irq_soft  (irq_soft),
    .rsp       (rsp)
  );

  function automatic logic [xlen-1:0] xorshift(input logic [xlen-1:0] s);
    logic [xlen-1:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic void clear_strobes();
    req.rden   = 1'b0;
    req.wren   = 1'b0;
    req.retire = 1'b0;
    req.exc    = 1'b0;
    req.mret   = 1'b0;
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    clear_strobes();
  endtask

  task automatic check_value(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    n_checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s: %s gave %h, expected %h", $time, test_name, what, got, exp);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s (test %s, time %0t)", msg, test_name, $time);
    n_errors++;
    test_errors++;
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
      n_tests++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Registered pulses are stable at the falling edge
  task automatic wait_pulse(input bit want_trap, output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < wait_limit && !seen; n++) begin
      seen = want_trap ? rsp.trap : rsp.mret_done;
      if (!seen) begin
        next_cycle();
      end
    end
  endtask

  task automatic run_op(input string kw, input logic [xlen-1:0] a, input logic [xlen-1:0] d,
                        input logic [xlen-1:0] c, input logic [xlen-1:0] e);
    bit    seen;
    bit    trapped;
    string what;
    what = $sformatf("%s %h", kw, a[11:0]);
    if (kw == "read") begin
      req.rden  = 1'b1;
      req.raddr = csr_addr_e'(a[11:0]);
      #1;
      if (c == 32'd0) begin
        check_value(what, rsp.rdata, e);
      end else if (c == 32'd1) begin
        check_value({what, " delta"}, rsp.rdata - prev_rd, e);
      end else if (c == 32'd2) begin
        check_value(what, rsp.rdata, last_wdata & e);  // Expect field holds the writable mask
      end
      prev_rd = rsp.rdata;
      next_cycle();
    end else if (kw == "write") begin
      if (c[0]) begin
        rng = xorshift(rng);
        last_wdata = rng;
      end else begin
        last_wdata = d;
      end
      req.wren  = 1'b1;
      req.waddr = csr_addr_e'(a[11:0]);
      req.wdata = last_wdata;
      next_cycle();
    end else if (kw == "idle") begin
      repeat (d) next_cycle();
    end else if (kw == "retire") begin
      repeat (d) begin
        req.retire = 1'b1;
        next_cycle();
      end
    end else if (kw == "irq") begin
      {irq_ext, irq_timer, irq_soft} = d[2:0];
      req.epc = a;
      next_cycle();
      if (c[0]) begin
        wait_pulse(1'b1, seen);
        if (seen) begin
          check_value("trap_pc", rsp.trap_pc, e);
        end else begin
          note_failure("No trap was taken after the interrupt lines rose");
        end
      end else begin
        trapped = 1'b0;
        repeat (quiet_cycles) begin
          trapped = trapped | rsp.trap;
          next_cycle();
        end
        check_value("unexpected trap", {{(xlen-1){1'b0}}, trapped}, '0);
      end
    end else if (kw == "exc") begin
      req.exc    = 1'b1;
      req.ecause = exc_cause_e'(c[3:0]);
      req.epc    = a;
      req.etval  = d;
      next_cycle();
      wait_pulse(1'b1, seen);
      if (seen) begin
        check_value("trap_pc", rsp.trap_pc, e);
      end else begin
        note_failure("Timed out waiting for the trap pulse after an exception");
      end
    end else if (kw == "mret") begin
      req.mret = 1'b1;
      if (d[0]) begin
        req.exc    = 1'b1;  // Exception in the same cycle
        req.ecause = exc_cause_e'(c[3:0]);
        req.epc    = a;
      end
      next_cycle();
      wait_pulse(d[0], seen);
      if (!seen) begin
        note_failure("Timed out waiting for the trap or mret_done pulse");
      end else if (d[0]) begin
        check_value("trap_pc", rsp.trap_pc, e);
        check_value("mret_done with trap", {{(xlen-1){1'b0}}, rsp.mret_done}, '0);
      end else begin
        check_value("ret_pc", rsp.ret_pc, e);
      end
    end else begin
      note_failure({"Unknown operation in stimulus file: ", kw});
    end
  endtask

  task automatic run_line(input string line);
    string           kw;
    string           name;
    logic [xlen-1:0] a;
    logic [xlen-1:0] d;
    logic [xlen-1:0] c;
    logic [xlen-1:0] e;
    void'($sscanf(line, "%s", kw));
    if (kw == "test") begin
      finish_test();
      void'($sscanf(line, "%s %s", kw, name));
      test_name = name;
    end else if ($sscanf(line, "%s %h %h %h %h", kw, a, d, c, e) != 5) begin
      note_failure({"Malformed stimulus line: ", line});
    end else begin
      run_op(kw, a, d, c, e);
    end
  endtask

  task automatic load_stim(output bit ok);
    int    fd;
    string line;
    ok = 1'b0;
    fd = $fopen("sim/csr_stim.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          stim_lines.push_back(line);
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired: stimulus did not finish within %0d cycles", wd_cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    bit ok;
    rst       = 1'b0;
    req       = '0;
    irq_ext   = 1'b0;
    irq_timer = 1'b0;
    irq_soft  = 1'b0;
    load_stim(ok);
    if (!ok) begin
      $display("Could not open the stimulus file sim/csr_stim.txt");
      $display("Checks failed");
      $finish;
    end else begin
      wd_cycles = stim_lines.size() * wd_per_line + wd_margin;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
      foreach (stim_lines[i]) begin
        run_line(stim_lines[i]);
      end
      finish_test();
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               n_tests, n_checks, n_errors, i_dut.i_assert.viol_cnt);
      if (n_errors == 0 && i_dut.i_assert.viol_cnt == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// ==== sim/csr_unit_assert.sv ====
`timescale 1ns/1ps

module csr_unit_assert
  import csr_pkg::*;
(
  input logic            clk,
  input logic            rst,
  input csr_req_t        req,
  input logic            trap,
  input logic            mret_done,
  input logic            mstatus_mie,
  input logic [xlen-1:0] mcause
);

  int viol_cnt = 0;  // Read by the testbench at the end of the run

  trap_new_cause: assert property (@(posedge clk) disable iff (!rst)
    trap && $past(trap) |-> mcause != $past(mcause))
  else begin
    $error("trap high on two cycles in a row with the same mcause");
    viol_cnt++;
  end

  // An mret beside an exception yields the trap alone
  trap_mret_excl: assert property (@(posedge clk) disable iff (!rst)
    $past(req.mret && req.exc) |-> trap && !mret_done)
  else begin
    $error("mret with an exception in the same cycle did not give a trap only");
    viol_cnt++;
  end

  // Entry clears mie, and only an exception traps while mie is clear
  trap_mie_clear: assert property (@(posedge clk) disable iff (!rst)
    trap |-> !mstatus_mie && ($past(req.exc) || $past(mstatus_mie)))
  else begin
    $error("trap without mstatus.mie cleared, or interrupt taken with mie clear");
    viol_cnt++;
  end

endmodule

bind csr_unit csr_unit_assert i_assert (
  .clk         (clk),
  .rst         (rst),
  .req         (req),
  .trap        (rsp.trap),
  .mret_done   (rsp.mret_done),
  .mstatus_mie (mstatus_mie),
  .mcause      (mcause)
);

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  csr_req_t req,
  input  logic     irq_ext,
  input  logic     irq_timer,
  input  logic     irq_soft,
  output csr_rsp_t rsp
);

  trap_take_t       take;
  mip_t             mip;
  mie_t             mie;
  logic             mstatus_mie;
  logic [xlen-1:0]  mtvec;
  logic [xlen-1:0]  mcause;
  logic [xlen-1:0]  mepc;
  logic [xlen-1:0]  rdata;
  logic [xlen-1:0]  trap_pc;
  logic             trap;
  logic             mret_done;
  logic [cnt_w-1:0] mcycle;
  logic [cnt_w-1:0] minstret;

  csr_regs i_csr_regs (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .take        (take),
    .mip         (mip),
    .mcycle      (mcycle),
    .minstret    (minstret),
    .mstatus_mie (mstatus_mie),
    .mie         (mie),
    .mtvec       (mtvec),
    .mcause      (mcause),
    .mepc        (mepc),
    .rdata       (rdata),
    .trap        (trap),
    .mret_done   (mret_done)
  );

  csr_counters i_csr_counters (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .mcycle   (mcycle),
    .minstret (minstret)
  );

  trap_ctrl i_trap_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .irq_ext     (irq_ext),
    .irq_timer   (irq_timer),
    .irq_soft    (irq_soft),
    .mstatus_mie (mstatus_mie),
    .mie         (mie),
    .mtvec       (mtvec),
    .mcause      (mcause),
    .take        (take),
    .mip         (mip),
    .trap_pc     (trap_pc)
  );

  assign rsp = '{rdata: rdata, trap: trap, mret_done: mret_done,
                 trap_pc: trap_pc, ret_pc: mepc};

endmodule

// ==== hdl/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl
  import csr_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  csr_req_t        req,
  input  logic            irq_ext,
  input  logic            irq_timer,
  input  logic            irq_soft,
  input  logic            mstatus_mie,
  input  mie_t            mie,
  input  logic [xlen-1:0] mtvec,
  input  logic [xlen-1:0] mcause,
  output trap_take_t      take,
  output mip_t            mip,
  output logic [xlen-1:0] trap_pc
);

  mip_t            mip_q;
  logic [xlen-1:0] base;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mip_q <= '0;
    end else begin
      if (req.wren && (req.waddr == csr_mip)) begin
        mip_q <= mip_t'(req.wdata & mip_sw_mask);
      end
      mip_q.meip <= irq_ext;  // Lines sampled every cycle
      mip_q.mtip <= irq_timer;
      mip_q.msip <= irq_soft;
    end
  end

  // Fixed priority: exception, external, timer, software
  always_comb begin
    take = '0;
    if (req.exc) begin
      take.take  = 1'b1;
      take.cause = req.ecause;
    end else if (mstatus_mie) begin
      if (mie.meie && mip_q.meip) begin
        take.take   = 1'b1;
        take.is_irq = 1'b1;
        take.cause  = irq_m_ext;
      end else if (mie.mtie && mip_q.mtip) begin
        take.take   = 1'b1;
        take.is_irq = 1'b1;
        take.cause  = irq_m_timer;
      end else if (mie.msie && mip_q.msip) begin
        take.take   = 1'b1;
        take.is_irq = 1'b1;
        take.cause  = irq_m_soft;
      end
    end
  end

  assign base = {mtvec[xlen-1:2], 2'b00};

  always_comb begin
    if (mtvec[1:0] == 2'b01 && mcause[xlen-1]) begin
      trap_pc = base + {mcause[xlen-3:0], 2'b00};  // Vectored
    end else begin
      trap_pc = base;
    end
  end

  assign mip = mip_q;

endmodule

// ==== hdl/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters
  import csr_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  csr_req_t         req,
  output logic [cnt_w-1:0] mcycle,
  output logic [cnt_w-1:0] minstret
);

  logic [cnt_w-1:0] mcycle_q;
  logic [cnt_w-1:0] minstret_q;

  // Half writes override the increment
  function automatic logic [cnt_w-1:0] count_next(
    input logic [cnt_w-1:0] cur,
    input logic             inc,
    input logic             wr_lo,
    input logic             wr_hi,
    input logic [xlen-1:0]  wdata
  );
    logic [cnt_w-1:0] nxt;
    nxt = cur + {{(cnt_w-1){1'b0}}, inc};
    if (wr_lo) begin
      nxt[xlen-1:0] = wdata;
    end
    if (wr_hi) begin
      nxt[cnt_w-1:xlen] = wdata;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= count_next(mcycle_q, 1'b1,
                             req.wren && (req.waddr == csr_mcycle),
                             req.wren && (req.waddr == csr_mcycleh), req.wdata);
      minstret_q <= count_next(minstret_q, req.retire,
                               req.wren && (req.waddr == csr_minstret),
                               req.wren && (req.waddr == csr_minstreth), req.wdata);
    end
  end

  assign mcycle   = mcycle_q;
  assign minstret = minstret_q;

endmodule

// ==== hdl/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs
  import csr_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  csr_req_t         req,
  input  trap_take_t       take,
  input  mip_t             mip,
  input  logic [cnt_w-1:0] mcycle,
  input  logic [cnt_w-1:0] minstret,
  output logic             mstatus_mie,
  output mie_t             mie,
  output logic [xlen-1:0]  mtvec,
  output logic [xlen-1:0]  mcause,
  output logic [xlen-1:0]  mepc,
  output logic [xlen-1:0]  rdata,
  output logic             trap,
  output logic             mret_done
);

  mstatus_t        mstatus_q;
  mstatus_t        mstatus_wr;
  misa_t           misa_q;
  mie_t            mie_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic            trap_q;
  logic            mret_q;

  function automatic logic wr_hit(input csr_addr_e addr);
    return req.wren && (req.waddr == addr);
  endfunction

  // Masked mstatus write with sd as the dirty summary
  always_comb begin
    mstatus_wr = mstatus_t'(req.wdata & mstatus_mask);
    mstatus_wr.sd = (mstatus_wr.fs == 2'b11) || (mstatus_wr.xs == 2'b11);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_q <= mstatus_rst;
      misa_q    <= misa_rst;
      mie_q     <= '0;
      mtvec_q   <= mtvec_rst;
      mcause_q  <= '0;
      trap_q    <= 1'b0;
      mret_q    <= 1'b0;
    end else begin
      trap_q <= take.take;
      mret_q <= req.mret && !take.take;  // Trap wins over mret

      if (take.take) begin
        mstatus_q.mpie <= mstatus_q.mie;
        mstatus_q.mie  <= 1'b0;
      end else if (req.mret) begin
        mstatus_q.mie  <= mstatus_q.mpie;
        mstatus_q.mpie <= 1'b1;
      end else if (wr_hit(csr_mstatus)) begin
        mstatus_q <= mstatus_wr;
      end

      if (take.take) begin
        mcause_q <= {take.is_irq, {(xlen-5){1'b0}}, take.cause};
      end else if (wr_hit(csr_mcause)) begin
        mcause_q <= req.wdata & mcause_mask;
      end

      if (wr_hit(csr_misa)) begin
        misa_q <= misa_t'(req.wdata & misa_mask);
      end
      if (wr_hit(csr_mie)) begin
        mie_q <= mie_t'(req.wdata & mie_mask);
      end
      if (wr_hit(csr_mtvec)) begin
        mtvec_q <= req.wdata & mtvec_mask;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (take.take) begin
      mepc_q  <= req.epc & mepc_mask;
      mtval_q <= req.etval;
    end else begin
      if (wr_hit(csr_mepc)) begin
        mepc_q <= req.wdata & mepc_mask;
      end
      if (wr_hit(csr_mtval)) begin
        mtval_q <= req.wdata;
      end
    end
    if (wr_hit(csr_mscratch)) begin
      mscratch_q <= req.wdata;
    end
  end

  always_comb begin
    rdata = '0;
    if (req.rden) begin
      case (req.raddr)
        csr_mstatus   : rdata = mstatus_q;
        csr_misa      : rdata = misa_q;
        csr_mie       : rdata = mie_q;
        csr_mtvec     : rdata = mtvec_q;
        csr_mscratch  : rdata = mscratch_q;
        csr_mepc      : rdata = mepc_q;
        csr_mcause    : rdata = mcause_q;
        csr_mtval     : rdata = mtval_q;
        csr_mip       : rdata = mip;
        csr_mcycle    : rdata = mcycle[xlen-1:0];
        csr_mcycleh   : rdata = mcycle[cnt_w-1:xlen];
        csr_minstret  : rdata = minstret[xlen-1:0];
        csr_minstreth : rdata = minstret[cnt_w-1:xlen];
        default       : rdata = '0;  // Unsupported address
      endcase
    end
  end

  assign mstatus_mie = mstatus_q.mie;
  assign mie         = mie_q;
  assign mtvec       = mtvec_q;
  assign mcause      = mcause_q;
  assign mepc        = mepc_q;
  assign trap        = trap_q;
  assign mret_done   = mret_q;

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

  localparam int xlen = 32;
  localparam int cnt_w = 2 * xlen;

  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_misa      = 12'h301,
    csr_mie       = 12'h304,
    csr_mtvec     = 12'h305,
    csr_mscratch  = 12'h340,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mtval     = 12'h343,
    csr_mip       = 12'h344,
    csr_mcycle    = 12'hb00,
    csr_minstret  = 12'hb02,
    csr_mcycleh   = 12'hb80,
    csr_minstreth = 12'hb82
  } csr_addr_e;

  typedef enum logic [3:0] {
    exc_instr_misalign = 4'd0,
    exc_illegal_instr  = 4'd2,
    exc_breakpoint     = 4'd3,
    exc_load_misalign  = 4'd4,
    exc_store_misalign = 4'd6,
    exc_ecall_m        = 4'd11
  } exc_cause_e;

  // Interrupt codes overlap breakpoint and ecall in mcause[3:0]
  localparam exc_cause_e irq_m_soft  = exc_cause_e'(4'd3);
  localparam exc_cause_e irq_m_timer = exc_cause_e'(4'd7);
  localparam exc_cause_e irq_m_ext   = exc_cause_e'(4'd11);

  typedef struct packed {
    logic       sd;
    logic [7:0] wpri3;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] mpp;
    logic [1:0] wpri2;
    logic       spp;
    logic       mpie;
    logic       wpri1;
    logic       spie;
    logic       upie;
    logic       mie;
    logic       wpri0;
    logic       sie;
    logic       uie;
  } mstatus_t;

  typedef struct packed {
    logic [1:0]  mxl;
    logic [3:0]  wlrl;
    logic [25:0] ext;  // Bit 0 is A, bit 25 is Z
  } misa_t;

  typedef struct packed {
    logic [19:0] res_hi;
    logic        meie;
    logic        res2;
    logic        seie;
    logic        ueie;
    logic        mtie;
    logic        res1;
    logic        stie;
    logic        utie;
    logic        msie;
    logic        res0;
    logic        ssie;
    logic        usie;
  } mie_t;

  typedef struct packed {
    logic [19:0] res_hi;
    logic        meip;
    logic        res2;
    logic        seip;
    logic        ueip;
    logic        mtip;
    logic        res1;
    logic        stip;
    logic        utip;
    logic        msip;
    logic        res0;
    logic        ssip;
    logic        usip;
  } mip_t;

  typedef struct packed {
    logic            rden;
    csr_addr_e       raddr;
    logic            wren;
    csr_addr_e       waddr;
    logic [xlen-1:0] wdata;
    logic            retire;
    logic            exc;
    exc_cause_e      ecause;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] etval;
    logic            mret;
  } csr_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            trap;
    logic            mret_done;
    logic [xlen-1:0] trap_pc;
    logic [xlen-1:0] ret_pc;
  } csr_rsp_t;

  typedef struct packed {
    logic       take;
    logic       is_irq;
    exc_cause_e cause;
  } trap_take_t;

  // Writable bits per register
  localparam logic [xlen-1:0] mstatus_mask = 32'h007f_f9bb;
  localparam logic [xlen-1:0] misa_mask    = 32'hc3ff_ffff;
  localparam logic [xlen-1:0] mie_mask     = 32'h0000_0bbb;
  localparam logic [xlen-1:0] mip_sw_mask  = 32'h0000_0333;  // S and U pending bits only
  localparam logic [xlen-1:0] mtvec_mask   = 32'hffff_fffd;  // Modes 0 and 1 only
  localparam logic [xlen-1:0] mepc_mask    = 32'hffff_fffc;  // No compressed ISA
  localparam logic [xlen-1:0] mcause_mask  = 32'h8000_000f;

  localparam mstatus_t mstatus_rst = 32'h0000_1800;  // mpp = M
  localparam misa_t    misa_rst    = 32'h4000_1100;  // RV32IM
  localparam logic [xlen-1:0] mtvec_rst = 32'h0000_0000;

endpackage
